//--- build.f
+incdir+testbench
source/vita_tx_pkg.sv
source/vita_tx_settings.sv
source/vita_tx_deframer.sv
source/vita_sample_fifo.sv
source/vita_tx_top.sv
testbench/vita_tx_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module vita_tx_tb \
   -f build.f -o vita_tx_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/vita_tx_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

//--- source/vita_sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module vita_sample_fifo (
   input  wire                            clk,
   input  wire                            arst_n_i,
   input  wire                            clear_i,
   input  wire                            push_i,
   input  wire vita_tx_pkg::sample_line_t push_line_i,
   output logic                           space_o,
   output vita_tx_pkg::sample_line_t      sample_line_o,
   output logic                           sample_src_rdy_o,
   input  wire                            sample_dst_rdy_i,
   output logic [15:0]                    occupied_o,
   output logic                           full_o,
   output logic                           empty_o
);

   import vita_tx_pkg::*;

   sample_line_t       mem [fifo_depth];
   logic [fifo_aw-1:0] wr_ptr_q;
   logic [fifo_aw-1:0] rd_ptr_q;
   logic [fifo_aw:0]   count_q;
   logic               pop;

   assign pop = sample_src_rdy_o && sample_dst_rdy_i;

   always_ff @(posedge clk)
   begin
      if (push_i)
         mem[wr_ptr_q] <= push_line_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push_i, pop})
            2'b10   : count_q <= count_q + 1'b1;
            2'b01   : count_q <= count_q - 1'b1;
            default : ;
         endcase
      end
   end

   assign sample_line_o    = mem[rd_ptr_q];
   assign empty_o          = (count_q == '0);
   assign full_o           = (count_q == (fifo_aw + 1)'(fifo_depth));
   assign space_o          = !full_o;
   assign sample_src_rdy_o = !empty_o;
   assign occupied_o       = 16'(count_q);

   a_no_overrun : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      !(push_i && full_o))
      else $error("push into a full sample queue");

endmodule

`default_nettype wire

//--- source/vita_tx_deframer.sv
`timescale 1ns/10ps
`default_nettype none

module vita_tx_deframer (
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire                          clear_i,
   input  wire [1:0]                    numchan_i,
   input  wire vita_tx_pkg::vita_word_t data_i,
   input  wire                          src_rdy_i,
   output logic                         dst_rdy_o,
   output logic                         push_o,
   output vita_tx_pkg::sample_line_t    push_line_o,
   input  wire                          space_i
);

   import vita_tx_pkg::*;

   typedef struct packed {
      logic sid;
      logic cid;
      logic secs;
      logic tics;
      logic trl;
      logic sob;
      logic eob;
   } hdr_flags_t;

   vita_state_t               state_q;
   hdr_flags_t                hdr_flags;   // decoded from the current word
   hdr_flags_t                flags_q;
   logic [15:0]               pkt_len_q;   // words left, header and trailer included
   logic [15:0]               hdr_len;
   logic [1:0]                phase_q;
   logic                      line_done;
   logic                      last_eof_q;
   logic                      eop;
   logic [max_chan-1:0][31:0] samples_q;
   logic [63:0]               send_time_q;

   // first optional word after the one just taken
   function automatic vita_state_t next_opt(input logic cid,
                                            input logic secs,
                                            input logic tics);
      vita_state_t nxt;
      if (cid)
         nxt = st_class_id;
      else if (secs)
         nxt = st_secs;
      else if (tics)
         nxt = st_tics;
      else
         nxt = st_payload;
      return nxt;
   endfunction

   always_comb
   begin
      hdr_flags.sid  = (data_i.data[31:28] == 4'd1);
      hdr_flags.cid  = data_i.data[27];
      hdr_flags.trl  = data_i.data[26];
      hdr_flags.sob  = data_i.data[25];
      hdr_flags.eob  = data_i.data[24];
      hdr_flags.secs = (data_i.data[23:22] != 2'b00);
      hdr_flags.tics = (data_i.data[21:20] != 2'b00);
   end

   assign hdr_len = 16'd2 + 16'(flags_q.sid) + 16'({flags_q.cid, 1'b0})
                  + 16'(flags_q.secs) + 16'({flags_q.tics, 1'b0}) + 16'(flags_q.trl);

   assign line_done = (phase_q == numchan_i);
   assign eop       = last_eof_q || (pkt_len_q == hdr_len);

   // no word is taken while a line waits in store
   assign dst_rdy_o = (state_q != st_store);
   assign push_o    = (state_q == st_store) && space_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q    <= st_header;
         flags_q    <= '0;
         pkt_len_q  <= 16'd0;
         phase_q    <= 2'd0;
         last_eof_q <= 1'b0;
      end
      else if (clear_i)
      begin
         state_q    <= st_header;
         flags_q    <= '0;
         pkt_len_q  <= 16'd0;
         phase_q    <= 2'd0;
         last_eof_q <= 1'b0;
      end
      else if (state_q == st_store)
      begin
         if (space_i)
         begin
            if (!eop)
               state_q <= st_payload;
            else if (flags_q.trl)
               state_q <= st_trailer;
            else
               state_q <= st_header;
         end
      end
      else if (src_rdy_i)
      begin
         case (state_q)
            st_header :
            begin
               flags_q    <= hdr_flags;
               pkt_len_q  <= data_i.data[15:0];
               phase_q    <= 2'd0;
               last_eof_q <= 1'b0;
               if (hdr_flags.sid)
                  state_q <= st_stream_id;
               else
                  state_q <= next_opt(hdr_flags.cid, hdr_flags.secs, hdr_flags.tics);
            end
            st_stream_id :
               state_q <= next_opt(flags_q.cid, flags_q.secs, flags_q.tics);
            st_class_id :
               state_q <= st_class_id2;
            st_class_id2 :
               state_q <= next_opt(1'b0, flags_q.secs, flags_q.tics);
            st_secs :
               state_q <= next_opt(1'b0, 1'b0, flags_q.tics);
            st_tics :
               state_q <= st_tics2;
            st_tics2 :
               state_q <= st_payload;
            st_payload :
            begin
               pkt_len_q  <= pkt_len_q - 16'd1;
               last_eof_q <= data_i.eof;
               if (line_done)
               begin
                  phase_q <= 2'd0;
                  state_q <= st_store;
               end
               else
                  phase_q <= phase_q + 2'd1;
            end
            st_trailer :
               state_q <= st_header;  // trailer word dropped
            default :
               state_q <= st_header;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == st_store)
      begin
         if (space_i)
            send_time_q <= 64'd0;  // later lines go out untimed
      end
      else if (src_rdy_i)
      begin
         case (state_q)
            st_header  : send_time_q        <= 64'd0;
            st_secs    : send_time_q[63:32] <= data_i.data;
            st_tics2   : send_time_q[31:0]  <= data_i.data;  // low half of tics
            st_payload : samples_q[phase_q] <= data_i.data;
            default    : ;
         endcase
      end
   end

   always_comb
   begin
      push_line_o.samples   = samples_q;
      push_line_o.has_time  = flags_q.secs;
      push_line_o.sob       = flags_q.sob;
      push_line_o.eob       = flags_q.eob;
      push_line_o.eop       = eop;
      push_line_o.send_time = send_time_q;
   end

   // a line never runs past the header length field
   a_push_in_packet : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      push_o |-> (pkt_len_q >= hdr_len))
      else $error("line pushed past the packet length");

endmodule

`default_nettype wire

//--- source/vita_tx_pkg.sv
`default_nettype none

package vita_tx_pkg;

   localparam int max_chan   = 4;   // sample slots per line
   localparam int fifo_depth = 16;
   localparam int fifo_aw    = $clog2(fifo_depth);

   // settings register map
   localparam logic [7:0] set_base         = 8'd0;
   localparam logic [7:0] set_addr_numchan = set_base + 8'd8;
   localparam logic [7:0] set_addr_clear   = set_base + 8'd9;

   // one word of the buffer pool stream
   typedef struct packed {
      logic [1:0]  spare;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } vita_word_t;

   typedef enum logic [3:0] {
      st_header    = 4'd0,
      st_stream_id = 4'd1,
      st_class_id  = 4'd2,
      st_class_id2 = 4'd3,
      st_secs      = 4'd4,
      st_tics      = 4'd5,
      st_tics2     = 4'd6,
      st_payload   = 4'd7,
      st_store     = 4'd8,
      st_trailer   = 4'd9
   } vita_state_t;

   typedef struct packed {
      logic [max_chan-1:0][31:0] samples;   // slot 0 in the low bits
      logic                      has_time;
      logic                      sob;
      logic                      eob;
      logic                      eop;
      logic [63:0]               send_time;  // secs in the upper half
   } sample_line_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

endpackage

`default_nettype wire

//--- source/vita_tx_settings.sv
`timescale 1ns/10ps
`default_nettype none

module vita_tx_settings (
   input  wire                        clk,
   input  wire                        arst_n_i,
   input  wire vita_tx_pkg::set_bus_t set_bus_i,
   output logic [1:0]                 numchan_o,
   output logic                       clear_o
);

   import vita_tx_pkg::*;

   logic wr_numchan;
   logic wr_clear;

   assign wr_numchan = set_bus_i.stb && (set_bus_i.addr == set_addr_numchan);
   assign wr_clear   = set_bus_i.stb && (set_bus_i.addr == set_addr_clear);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         numchan_o <= 2'd0;
         clear_o   <= 1'b0;
      end
      else
      begin
         if (wr_numchan)
            numchan_o <= set_bus_i.data[1:0];  // channels minus one
         clear_o <= wr_clear;
      end
   end

   a_clear_single : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      clear_o |=> !clear_o)
      else $error("clear pulse longer than one cycle");

endmodule

`default_nettype wire

//--- source/vita_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module vita_tx_top (
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire vita_tx_pkg::set_bus_t   set_bus_i,
   input  wire vita_tx_pkg::vita_word_t data_i,
   input  wire                          src_rdy_i,
   output wire                          dst_rdy_o,
   output vita_tx_pkg::sample_line_t    sample_line_o,
   output wire                          sample_src_rdy_o,
   input  wire                          sample_dst_rdy_i,
   output wire [15:0]                   fifo_occupied_o,
   output wire                          fifo_full_o,
   output wire                          fifo_empty_o
);

   import vita_tx_pkg::*;

   logic [1:0]   numchan;
   logic         clear;
   logic         push;
   sample_line_t push_line;
   logic         space;

   vita_tx_settings u_settings (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .set_bus_i (set_bus_i),
      .numchan_o (numchan),
      .clear_o   (clear)
   );

   vita_tx_deframer u_deframer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear),
      .numchan_i   (numchan),
      .data_i      (data_i),
      .src_rdy_i   (src_rdy_i),
      .dst_rdy_o   (dst_rdy_o),
      .push_o      (push),
      .push_line_o (push_line),
      .space_i     (space)
   );

   vita_sample_fifo u_fifo (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .clear_i          (clear),
      .push_i           (push),
      .push_line_i      (push_line),
      .space_o          (space),
      .sample_line_o    (sample_line_o),
      .sample_src_rdy_o (sample_src_rdy_o),
      .sample_dst_rdy_i (sample_dst_rdy_i),
      .occupied_o       (fifo_occupied_o),
      .full_o           (fifo_full_o),
      .empty_o          (fifo_empty_o)
   );

endmodule

`default_nettype wire

//--- testbench/vita_tx_model.svh
`ifndef VITA_TX_MODEL_SVH
`define VITA_TX_MODEL_SVH

sample_line_t exp_q[$];        // expected lines, oldest first
int           exp_slots_q[$];  // slots in use for each expected line

// expected lines for the packet held in pkt_q
task automatic model_packet(input int nchan);
   sample_line_t line;
   logic [31:0]  hdr;
   int           idx;
   int           last;
   int           slot;
   int           i;
   hdr  = pkt_q[0].data;
   idx  = 1;
   line = '0;
   if (hdr[31:28] == 4'd1)
      idx = idx + 1;           // stream id
   if (hdr[27])
      idx = idx + 2;           // class id pair
   if (hdr[23:22] != 2'b00)
   begin
      line.send_time[63:32] = pkt_q[idx].data;
      idx = idx + 1;
   end
   if (hdr[21:20] != 2'b00)
   begin
      line.send_time[31:0] = pkt_q[idx + 1].data;  // second tics word is the low half
      idx = idx + 2;
   end
   last          = pkt_q.size() - (hdr[26] ? 2 : 1);
   line.has_time = (hdr[23:22] != 2'b00);
   line.sob      = hdr[25];
   line.eob      = hdr[24];
   slot          = 0;
   for (i = idx; i <= last; i++)
   begin
      line.samples[slot] = pkt_q[i].data;
      if (slot == nchan)
      begin
         line.eop = (i == last);
         exp_q.push_back(line);
         exp_slots_q.push_back(nchan + 1);
         line.samples   = '0;
         line.send_time = 64'd0;  // time only on the first line
         slot           = 0;
      end
      else
         slot = slot + 1;
   end
endtask

task automatic compare_line(input string what, input sample_line_t exp,
                            input sample_line_t act, input int slots);
   sample_line_t e;
   sample_line_t a;
   int           s;
   e = exp;
   a = act;
   for (s = slots; s < max_chan; s++)
   begin
      e.samples[s] = '0;
      a.samples[s] = '0;
   end
   check_cnt = check_cnt + 1;
   if (e !== a)
   begin
      err_cnt = err_cnt + 1;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, e, a);
   end
endtask

task automatic compare_level(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
   check_cnt = check_cnt + 1;
   if (exp !== act)
   begin
      err_cnt = err_cnt + 1;
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
   end
endtask

`endif

//--- testbench/vita_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vita_tx_tb;

   import vita_tx_pkg::*;

   localparam int n_pkts          = 8;
   localparam int max_lines       = 6;
   localparam int max_pkt_words   = 10 + max_lines * max_chan;
   localparam int total_pkts      = 8 * n_pkts + 3;
   localparam int watchdog_cycles = total_pkts * max_pkt_words * 40;

   logic         clk;
   logic         arst_n_i;
   set_bus_t     set_bus_i;
   vita_word_t   data_i;
   logic         src_rdy_i;
   logic         dst_rdy_o;
   sample_line_t sample_line_o;
   logic         sample_src_rdy_o;
   logic         sample_dst_rdy_i;
   logic [15:0]  fifo_occupied_o;
   logic         fifo_full_o;
   logic         fifo_empty_o;

   logic [1:0]   bp_mode;   // 0 ready, 1 random stalls, 2 held off
   vita_word_t   pkt_q[$];
   string        test_name;
   int           check_cnt;
   int           err_cnt;
   int           line_cnt;
   int           test_errs;
   int           test_lines;

   `include "vita_tx_model.svh"

   vita_tx_top UUT (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .set_bus_i        (set_bus_i),
      .data_i           (data_i),
      .src_rdy_i        (src_rdy_i),
      .dst_rdy_o        (dst_rdy_o),
      .sample_line_o    (sample_line_o),
      .sample_src_rdy_o (sample_src_rdy_o),
      .sample_dst_rdy_i (sample_dst_rdy_i),
      .fifo_occupied_o  (fifo_occupied_o),
      .fifo_full_o      (fifo_full_o),
      .fifo_empty_o     (fifo_empty_o)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   initial
   begin
      repeat (watchdog_cycles)
         @(posedge clk);
      $display("timeout after %0d cycles in test %s", watchdog_cycles, test_name);
      $display("Regression failed");
      $finish;
   end

   // queue flags and output transfers, values from before the edge
   task automatic watch_outputs();
      sample_line_t exp_line;
      int           slots;
      compare_level("empty flag", 16'(fifo_occupied_o == 16'd0), 16'(fifo_empty_o));
      compare_level("full flag", 16'(fifo_occupied_o == 16'(fifo_depth)), 16'(fifo_full_o));
      compare_level("src ready", 16'(!fifo_empty_o), 16'(sample_src_rdy_o));
      if (fifo_occupied_o > 16'(fifo_depth))
      begin
         err_cnt = err_cnt + 1;
         $display("%s: occupancy %0d is above the queue depth", test_name, fifo_occupied_o);
      end
      if (sample_src_rdy_o && sample_dst_rdy_i)
      begin
         if (exp_q.size() == 0)
         begin
            err_cnt = err_cnt + 1;
            $display("%s: a line came out with none expected", test_name);
         end
         else
         begin
            exp_line = exp_q.pop_front();
            slots    = exp_slots_q.pop_front();
            compare_line("line", exp_line, sample_line_o, slots);
            line_cnt = line_cnt + 1;
         end
      end
   endtask

   task automatic step();
      @(posedge clk);
      watch_outputs();
      case (bp_mode)
         2'd1    : sample_dst_rdy_i <= ($urandom_range(15) == 0);  // mostly stalled
         2'd2    : sample_dst_rdy_i <= 1'b0;
         default : sample_dst_rdy_i <= 1'b1;
      endcase
   endtask

   task automatic send_word(input vita_word_t w);
      logic taken;
      taken = 1'b0;
      data_i    <= w;
      src_rdy_i <= ($urandom_range(3) != 0);
      while (!taken)
      begin
         step();
         if (src_rdy_i && dst_rdy_o)
            taken = 1'b1;
         else
            src_rdy_i <= ($urandom_range(3) != 0);
      end
   endtask

   task automatic send_words(input int count);
      int i;
      for (i = 0; i < count; i++)
         send_word(pkt_q[i]);
      src_rdy_i <= 1'b0;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] value);
      set_bus_t bus;
      bus.stb   = 1'b1;
      bus.addr  = addr;
      bus.data  = value;
      set_bus_i <= bus;
      step();
      set_bus_i <= '0;
      step();
      step();  // clear pulse has landed by now
   endtask

   task automatic build_packet(input logic sid, input logic cid, input logic trl,
                               input logic timed, input int nlines, input int nchan);
      logic [31:0] hdr;
      vita_word_t  w;
      int          len;
      int          i;
      // header length rule plus payload
      len = 2 + int'(sid) + 2 * int'(cid) + (timed ? 3 : 0) + int'(trl)
          + nlines * (nchan + 1);
      hdr        = 32'd0;
      hdr[31:28] = sid ? 4'd1 : 4'd0;
      hdr[27]    = cid;
      hdr[26]    = trl;
      hdr[25]    = 1'($urandom_range(1));
      hdr[24]    = 1'($urandom_range(1));
      hdr[23:22] = timed ? 2'($urandom_range(3, 1)) : 2'd0;
      hdr[21:20] = timed ? 2'($urandom_range(3, 1)) : 2'd0;
      hdr[19:16] = 4'($urandom);  // sequence number
      hdr[15:0]  = 16'(len);
      pkt_q.delete();
      w      = '0;
      w.sof  = 1'b1;
      w.data = hdr;
      pkt_q.push_back(w);
      w.sof = 1'b0;
      for (i = 0; i < len - 2; i++)
      begin
         w.data = $urandom;
         pkt_q.push_back(w);
      end
      w     = pkt_q[pkt_q.size() - 1];
      w.eof = 1'b1;
      pkt_q[pkt_q.size() - 1] = w;
   endtask

   task automatic drain_queue();
      while (exp_q.size() != 0)
         step();
   endtask

   // opt_mode 0 plain, 1 timed, 2 random options
   task automatic run_packets(input int count, input int nchan, input int opt_mode);
      logic sid;
      logic cid;
      logic trl;
      logic timed;
      int   i;
      for (i = 0; i < count; i++)
      begin
         sid   = (opt_mode == 2) && ($urandom_range(1) == 1);
         cid   = (opt_mode == 2) && ($urandom_range(1) == 1);
         trl   = (opt_mode == 2) && ($urandom_range(1) == 1);
         timed = (opt_mode == 1) || ((opt_mode == 2) && ($urandom_range(1) == 1));
         build_packet(sid, cid, trl, timed, $urandom_range(max_lines, 1), nchan);
         model_packet(nchan);
         send_words(pkt_q.size());
      end
      drain_queue();
   endtask

   task automatic begin_test(input string name);
      test_name  = name;
      test_errs  = err_cnt;
      test_lines = line_cnt;
   endtask

   task automatic end_test();
      $display("test %s: %0d lines, %0d errors", test_name, line_cnt - test_lines,
               err_cnt - test_errs);
   endtask

   initial
   begin
      int nc;
      void'($urandom(32'h3a89b9c4));
      arst_n_i         = 1'b0;
      set_bus_i        = '0;
      data_i           = '0;
      src_rdy_i        = 1'b0;
      sample_dst_rdy_i = 1'b1;
      bp_mode          = 2'd0;
      check_cnt        = 0;
      err_cnt          = 0;
      line_cnt         = 0;
      test_name        = "reset";
      repeat (10)
         @(posedge clk);
      arst_n_i <= 1'b1;
      step();
      compare_level("occupancy after reset", 16'd0, fifo_occupied_o);

      begin_test("plain");
      run_packets(n_pkts, 0, 0);
      end_test();
      begin_test("timed");
      run_packets(n_pkts, 0, 1);
      end_test();
      begin_test("skipped");
      run_packets(n_pkts, 0, 2);
      end_test();

      begin_test("channels");
      for (nc = 1; nc <= 3; nc++)
      begin
         write_setting(set_addr_numchan, 32'(nc));
         run_packets(n_pkts, nc, 2);
      end
      end_test();

      begin_test("backpressure");
      nc = $urandom_range(3);
      write_setting(set_addr_numchan, 32'(nc));
      bp_mode = 2'd1;
      run_packets(2 * n_pkts, nc, 2);
      bp_mode = 2'd0;
      end_test();

      begin_test("clear");
      write_setting(set_addr_numchan, 32'd1);
      bp_mode = 2'd2;
      step();
      build_packet(1'b0, 1'b0, 1'b0, 1'b1, 4, 1);
      model_packet(1);
      send_words(7);  // header, time, one line, one more sample
      step();
      compare_level("queued before clear", 16'd1, fifo_occupied_o);
      write_setting(set_addr_clear, 32'd0);
      compare_level("queued after clear", 16'd0, fifo_occupied_o);
      compare_level("empty after clear", 16'd1, 16'(fifo_empty_o));
      exp_q.delete();
      exp_slots_q.delete();
      bp_mode = 2'd0;
      run_packets(2, 1, 2);
      end_test();

      $display("checks %0d, lines %0d, errors %0d", check_cnt, line_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire
